// ==== project.f ====
+incdir+verilog
verilog/coh_pkg.sv
verilog/l1_dcache.sv
verilog/bus_ctrl.sv
verilog/l2_mem.sv
verilog/coherence_top.sv
dv/tb_coherence.sv

// ==== Bender.yml ====
package:
  name: coherence_subsystem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/coh_pkg.sv
      - verilog/l1_dcache.sv
      - verilog/bus_ctrl.sv
      - verilog/l2_mem.sv
      - verilog/coherence_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_coherence.sv

// ==== dv/tb_coherence.sv ====
`timescale 1ns/100ps
`include "coh_defs.svh"

module tb_coherence import coh_pkg::*; ();

    localparam int RANDOM_ACCESSES = 300;
    localparam int TOTAL_ACCESSES  = 18 + RANDOM_ACCESSES;   // Directed tests issue 18
    localparam int TIMEOUT_CYCLES  = 200 * TOTAL_ACCESSES;

    logic                   CLK;
    logic                   rst;
    logic   [`NUM_CPUS-1:0] ren;
    logic   [`NUM_CPUS-1:0] wen;
    addr_t  [`NUM_CPUS-1:0] addr;
    word_t  [`NUM_CPUS-1:0] wdata;
    word_t  [`NUM_CPUS-1:0] rdata;
    logic   [`NUM_CPUS-1:0] busy;

    word_t       ref_mem [`L2_WORDS];   // Expected contents per word
    logic   [`NUM_CPUS-1:0] busy_first; // busy in the first cycle of the last access
    int          errors;
    int          cycles;
    logic [31:0] rng;

    coherence_top uut (
        .CLK   (CLK),
        .rst   (rst),
        .ren   (ren),
        .wen   (wen),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .busy  (busy)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;           // 20 ns period
    end

    // Run limit scales with the number of accesses
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a request never completed", cycles);
            $display("Errors: %0d", errors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 16 words over sets 0 to 2 and tags 0 to 2
    function automatic addr_t pool_addr(input logic [3:0] k);
        int line;
        line = k[3:1];
        return addr_t'((line / 3) * 64 + (line % 3) * 8 + k[0] * 4);
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input string name, input logic [`NUM_CPUS-1:0] got,
                               input logic [`NUM_CPUS-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Drives one CPU's processor port
    task automatic drive_port(input int cpu, input logic r, input logic w,
                              input addr_t a, input word_t d);
        if (cpu == 0) begin
            ren[0]   <= r;
            wen[0]   <= w;
            addr[0]  <= a;
            wdata[0] <= d;
        end else begin
            ren[1]   <= r;
            wen[1]   <= w;
            addr[1]  <= a;
            wdata[1] <= d;
        end
    endtask

    // One processor access, checked against the reference model
    task automatic access(input int cpu, input logic is_write, input addr_t a, input word_t d);
        word_t exp;
        @(posedge CLK);
        drive_port(cpu, !is_write, is_write, a, d);
        @(negedge CLK);
        busy_first = busy;                                 // Low here only on a hit
        while (busy[cpu]) @(negedge CLK);                  // Completes at the next edge
        if (is_write) begin
            ref_mem[a[9:2]] = d;
        end else begin
            exp = ref_mem[a[9:2]];
            check_word($sformatf("uut.rdata[%0d]", cpu), rdata[cpu], exp);
        end
        @(posedge CLK);
        drive_port(cpu, 1'b0, 1'b0, a, d);                 // Strobes drop after the edge
    endtask

    task automatic test_cold_read();
        access(0, 1'b0, 32'h40, '0);                       // Miss filled from L2
        check_flags("uut.busy", busy_first, 2'b01);        // Miss stalls CPU 0
        access(0, 1'b0, 32'h44, '0);                       // Other word hits
        check_flags("uut.busy", busy_first, 2'b00);
    endtask

    task automatic test_write_readback();
        access(0, 1'b1, 32'h88, 32'h1234_5678);            // Write miss puts the line in M
        access(0, 1'b0, 32'h88, '0);
        access(0, 1'b1, 32'h88, 32'h9abc_def0);            // Hit in M
        check_flags("uut.busy", busy_first, 2'b00);        // No stall on an M write hit
        access(0, 1'b0, 32'h88, '0);
    endtask

    task automatic test_dirty_supply();
        access(0, 1'b1, 32'h110, 32'ha5a5_0110);
        access(1, 1'b0, 32'h110, '0);                      // M to S with L2 update
        access(0, 1'b0, 32'h150, '0);                      // Conflict evicts A on both
        access(1, 1'b0, 32'h150, '0);
        access(1, 1'b0, 32'h110, '0);                      // Now from L2
    endtask

    task automatic test_upgrade_inv();
        access(0, 1'b0, 32'h1a0, '0);
        access(1, 1'b0, 32'h1a0, '0);                      // Both in S
        access(1, 1'b1, 32'h1a0, 32'h5a5a_01a0);           // Upgrade invalidates CPU 0
        access(0, 1'b0, 32'h1a0, '0);
    endtask

    task automatic test_evict_refill();
        access(0, 1'b1, 32'h1e8, 32'hc0de_01e8);
        access(0, 1'b1, 32'h228, 32'hc0de_0228);           // Same set so the M victim goes back
        access(0, 1'b0, 32'h1e8, '0);
    endtask

    task automatic test_random();
        int          issued;
        logic [31:0] r;
        logic [3:0]  k0;
        logic [3:0]  k1;
        word_t       d0;
        word_t       d1;
        issued = 0;
        while (issued < RANDOM_ACCESSES) begin
            rng = xorshift32(rng);
            r   = rng;
            k0  = r[3:0];
            k1  = r[11:8];
            rng = xorshift32(rng);
            d0  = rng;
            rng = xorshift32(rng);
            d1  = rng;
            if (r[7:6] == 2'b00 && issued <= RANDOM_ACCESSES - 2) begin
                if (k1 == k0) k1 = k0 ^ 4'd1;              // Distinct words keep order free
                fork
                    access(0, r[5], pool_addr(k0), d0);
                    access(1, r[12], pool_addr(k1), d1);
                join
                issued += 2;
            end else begin
                access(int'(r[4]), r[5], pool_addr(k0), d0);
                issued += 1;
            end
        end
    endtask

    initial begin
        rst    = 1'b1;
        ren    = '0;
        wen    = '0;
        addr   = '0;
        wdata  = '0;
        errors = 0;
        cycles = 0;
        rng    = 32'd72;
        for (int i = 0; i < `L2_WORDS; i++) begin
            ref_mem[i] = word_t'(i * 4);                   // Each word holds its address
        end
        repeat (5) @(posedge CLK);
        rst <= 1'b0;
        test_cold_read();
        test_write_readback();
        test_dirty_supply();
        test_upgrade_inv();
        test_evict_refill();
        test_random();
        repeat (2) @(posedge CLK);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog/coherence_top.sv ====
`timescale 1ns/100ps
`include "coh_defs.svh"

module coherence_top import coh_pkg::*; (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic   [`NUM_CPUS-1:0]    ren,
    input  logic   [`NUM_CPUS-1:0]    wen,
    input  addr_t  [`NUM_CPUS-1:0]    addr,
    input  word_t  [`NUM_CPUS-1:0]    wdata,
    output word_t  [`NUM_CPUS-1:0]    rdata,
    output logic   [`NUM_CPUS-1:0]    busy
);

    // Cache to bus, one slot per CPU
    logic   [`NUM_CPUS-1:0] dREN;
    logic   [`NUM_CPUS-1:0] dWEN;
    logic   [`NUM_CPUS-1:0] ccwrite;
    addr_t  [`NUM_CPUS-1:0] daddr;
    block_t [`NUM_CPUS-1:0] dstore;
    logic   [`NUM_CPUS-1:0] dwait;
    logic   [`NUM_CPUS-1:0] ccexclusive;
    logic   [`NUM_CPUS-1:0] ccsnoop;
    logic   [`NUM_CPUS-1:0] ccinv;
    logic   [`NUM_CPUS-1:0] ccsnoopdone;
    logic   [`NUM_CPUS-1:0] ccsnoophit;
    logic   [`NUM_CPUS-1:0] ccdirty;
    block_t                 dload;          // Shared fill bus
    addr_t                  ccsnoopaddr;

    // Bus to L2
    logic      l2REN;
    logic      l2WEN;
    addr_t     l2addr;
    word_t     l2store;
    word_t     l2load;
    l2_state_t l2state;

    for (genvar i = 0; i < `NUM_CPUS; i++) begin : g_cpu
        l1_dcache #(.CPU_ID(cpu_id_t'(i))) u_l1 (
            .CLK         (CLK),
            .rst         (rst),
            .ren         (ren[i]),
            .wen         (wen[i]),
            .addr        (addr[i]),
            .wdata       (wdata[i]),
            .busy        (busy[i]),
            .rdata       (rdata[i]),
            .dwait       (dwait[i]),
            .dload       (dload),
            .ccexclusive (ccexclusive[i]),
            .dREN        (dREN[i]),
            .dWEN        (dWEN[i]),
            .ccwrite     (ccwrite[i]),
            .daddr       (daddr[i]),
            .dstore      (dstore[i]),
            .ccsnoop     (ccsnoop[i]),
            .ccinv       (ccinv[i]),
            .ccsnoopaddr (ccsnoopaddr),
            .ccsnoopdone (ccsnoopdone[i]),
            .ccsnoophit  (ccsnoophit[i]),
            .ccdirty     (ccdirty[i])
        );
    end

    bus_ctrl u_bus (.*);    // Names match one to one

    l2_mem u_l2 (.*);

endmodule

// ==== verilog/l2_mem.sv ====
`timescale 1ns/100ps
`include "coh_defs.svh"

module l2_mem import coh_pkg::*; (
    input  logic      CLK,
    input  logic      rst,
    input  logic      l2REN,
    input  logic      l2WEN,
    input  addr_t     l2addr,     // Word address
    input  word_t     l2store,
    output word_t     l2load,
    output l2_state_t l2state
);

    localparam int AW = $clog2(`L2_WORDS);
    localparam int CW = $clog2(`L2_LATENCY) + 1;

    word_t         mem [`L2_WORDS];
    logic [AW-1:0] widx;
    logic [CW-1:0] cnt;           // Cycles spent in L2_BUSY
    logic          lat_done;

    assign widx     = l2addr[AW-1:0];
    assign lat_done = (cnt == CW'(`L2_LATENCY - 1));

    // Each word starts out holding its own byte address
    initial begin
        for (int i = 0; i < `L2_WORDS; i++) begin
            mem[i] = word_t'(i * 4);
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            l2state <= L2_FREE;
            cnt     <= '0;
        end else begin
            case (l2state)
                L2_FREE: begin
                    if (l2REN || l2WEN) begin
                        l2state <= L2_BUSY;
                        cnt     <= '0;
                    end
                end
                L2_BUSY: begin
                    if (lat_done) l2state <= L2_ACCESS;
                    else          cnt     <= cnt + 1'b1;
                end
                default: l2state <= L2_FREE;    // One ACCESS cycle per word
            endcase
        end
    end

    always @(posedge CLK) begin
        if (l2state == L2_BUSY && lat_done) begin
            l2load <= mem[widx];                // Valid through L2_ACCESS
        end
        if (l2state == L2_ACCESS && l2WEN) begin
            mem[widx] <= l2store;
        end
    end

    a_rw_excl: assert property (@(posedge CLK) disable iff (rst) !(l2REN && l2WEN))
        else $error("l2_mem: l2REN and l2WEN both high");

    // Strobe stays up for the whole access
    a_strobe_held: assert property (@(posedge CLK) disable iff (rst)
        (l2state != L2_FREE) |-> (l2REN || l2WEN))
        else $error("l2_mem: strobe dropped during an access");

endmodule

// ==== verilog/bus_ctrl.sv ====
`timescale 1ns/100ps
`include "coh_defs.svh"

module bus_ctrl import coh_pkg::*; (
    input  logic                       CLK,
    input  logic                       rst,
    // Cache requests
    input  logic      [`NUM_CPUS-1:0]  dREN,
    input  logic      [`NUM_CPUS-1:0]  dWEN,
    input  logic      [`NUM_CPUS-1:0]  ccwrite,
    input  addr_t     [`NUM_CPUS-1:0]  daddr,
    input  block_t    [`NUM_CPUS-1:0]  dstore,
    output logic      [`NUM_CPUS-1:0]  dwait,
    output block_t                     dload,
    // Snoop broadcast
    output logic      [`NUM_CPUS-1:0]  ccsnoop,
    output logic      [`NUM_CPUS-1:0]  ccinv,
    output logic      [`NUM_CPUS-1:0]  ccexclusive,
    output addr_t                      ccsnoopaddr,
    input  logic      [`NUM_CPUS-1:0]  ccsnoopdone,
    input  logic      [`NUM_CPUS-1:0]  ccsnoophit,
    input  logic      [`NUM_CPUS-1:0]  ccdirty,
    // L2 side
    output logic                       l2REN,
    output logic                       l2WEN,
    output addr_t                      l2addr,
    output word_t                      l2store,
    input  word_t                      l2load,
    input  l2_state_t                  l2state
);

    bus_state_t           state;
    cpu_id_t              req_id;     // Current or last served requester
    cpu_id_t              other;
    cpu_id_t              pick;
    logic [`NUM_CPUS-1:0] req_any;
    logic                 word_sel;   // Block half on the L2 side
    logic                 hit_q;
    logic                 dirty_q;
    logic                 inv_q;
    logic                 l2_done;
    block_t               blk_q;      // Block headed for the requester

    assign req_any = dREN | dWEN;
    // Round robin on a tie, the last winner yields
    assign pick    = (&req_any) ? cpu_id_t'(~req_id) : cpu_id_t'(req_any[1]);
    assign other   = cpu_id_t'(~req_id);
    assign l2_done = (l2state == L2_ACCESS);

    assign dload       = blk_q;
    assign ccsnoopaddr = daddr[req_id];
    assign l2addr      = {2'b00, daddr[req_id][31:3], word_sel};   // Word address

    always_comb begin
        dwait       = '1;
        ccsnoop     = '0;
        ccinv       = '0;
        ccexclusive = '0;
        l2REN       = 1'b0;
        l2WEN       = 1'b0;
        l2store     = word_sel ? blk_q[63:32] : blk_q[31:0];
        case (state)
            GRANT_R:  ccsnoop[other] = 1'b1;
            GRANT_RX: begin
                ccsnoop[other] = 1'b1;
                ccinv[other]   = 1'b1;                  // Other copy must go to I
            end
            SNOOP:    ccinv[other] = inv_q;
            READ_L2:  l2REN = 1'b1;
            WRITE_L2: l2WEN = 1'b1;                     // Dirty supplier block into L2
            WRITEBACK: begin
                l2WEN   = 1'b1;
                l2store = word_sel ? dstore[req_id][63:32] : dstore[req_id][31:0];
            end
            BUS_TO_CACHE: begin
                dwait[req_id]       = 1'b0;
                ccexclusive[req_id] = !hit_q;           // No other copy seen
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state    <= IDLE;
            req_id   <= '1;                             // CPU 0 wins the first tie
            word_sel <= 1'b0;
            hit_q    <= 1'b0;
            dirty_q  <= 1'b0;
            inv_q    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (|req_any) begin
                        req_id   <= pick;
                        word_sel <= 1'b0;
                        inv_q    <= ccwrite[pick] && !dWEN[pick];
                        if (dWEN[pick])         state <= WRITEBACK;
                        else if (ccwrite[pick]) state <= GRANT_RX;
                        else                    state <= GRANT_R;
                    end
                end
                GRANT_R, GRANT_RX: state <= SNOOP;
                SNOOP: begin
                    if (ccsnoopdone[other]) begin
                        hit_q   <= ccsnoophit[other];
                        dirty_q <= ccdirty[other];
                        state   <= ccsnoophit[other] ? TRANSFER : READ_L2;
                    end
                end
                TRANSFER: begin
                    word_sel <= 1'b0;
                    state    <= dirty_q ? WRITE_L2 : BUS_TO_CACHE;
                end
                READ_L2, WRITE_L2, WRITEBACK: begin
                    if (l2_done) begin
                        word_sel <= ~word_sel;
                        if (word_sel) state <= BUS_TO_CACHE;    // Upper word was last
                    end
                end
                BUS_TO_CACHE: state <= IDLE;
                default:      state <= IDLE;
            endcase
        end
    end

    // Supplier block on snoop done, L2 words as they arrive
    always_ff @(posedge CLK) begin
        if (state == SNOOP && ccsnoopdone[other] && ccsnoophit[other]) begin
            blk_q <= dstore[other];
        end else if (state == READ_L2 && l2_done) begin
            if (word_sel) blk_q[63:32] <= l2load;
            else          blk_q[31:0]  <= l2load;
        end
    end

    a_one_release: assert property (@(posedge CLK) disable iff (rst) $countones(~dwait) <= 1)
        else $error("bus_ctrl: dwait low for more than one cache");

    a_inv_phase: assert property (@(posedge CLK) disable iff (rst)
        (|ccinv) |-> (state inside {GRANT_RX, SNOOP}))
        else $error("bus_ctrl: ccinv outside the invalidation phase");

endmodule

// ==== verilog/l1_dcache.sv ====
`timescale 1ns/100ps
`include "coh_defs.svh"

module l1_dcache import coh_pkg::*; #(
    parameter cpu_id_t CPU_ID = '0
) (
    input  logic   CLK,
    input  logic   rst,
    // Processor port
    input  logic   ren,
    input  logic   wen,
    input  addr_t  addr,
    input  word_t  wdata,
    output logic   busy,
    output word_t  rdata,
    // Bus request port
    input  logic   dwait,
    input  block_t dload,
    input  logic   ccexclusive,
    output logic   dREN,
    output logic   dWEN,
    output logic   ccwrite,
    output addr_t  daddr,
    output block_t dstore,
    // Snoop port
    input  logic   ccsnoop,
    input  logic   ccinv,
    input  addr_t  ccsnoopaddr,
    output logic   ccsnoopdone,
    output logic   ccsnoophit,
    output logic   ccdirty
);

    typedef enum logic [1:0] {M_IDLE, M_WB, M_FILL} miss_state_t;

    tag_t   tag_arr   [`L1_SETS];
    mesi_t  state_arr [`L1_SETS];
    block_t data_arr  [`L1_SETS];

    miss_state_t mstate;
    block_t      snoop_data_q;     // Block captured for a snoop supply

    index_t p_idx;
    tag_t   p_tag;
    logic   p_woff;
    mesi_t  p_state;
    logic   p_hit;
    logic   p_done;                // Request finishes this cycle
    logic   victim_dirty;

    index_t s_idx;
    tag_t   s_tag;
    mesi_t  s_state;
    logic   s_hit;

    // Processor lookup
    assign p_idx   = addr[5:3];
    assign p_tag   = addr[31:6];
    assign p_woff  = addr[2];
    assign p_state = state_arr[p_idx];
    assign p_hit   = (p_state != INVALID) && (tag_arr[p_idx] == p_tag);

    // Reads hit in any valid state, writes only in E or M
    // A snoop owns the arrays in its strobe cycle
    assign p_done = (mstate == M_IDLE) && !ccsnoop && p_hit &&
                    (ren || p_state == EXCLUSIVE || p_state == MODIFIED);
    assign busy   = (ren || wen) && !p_done;
    assign rdata  = p_woff ? data_arr[p_idx][63:32] : data_arr[p_idx][31:0];

    assign victim_dirty = (p_state == MODIFIED) && (tag_arr[p_idx] != p_tag);

    // Bus requests straight from the miss state
    assign dREN    = (mstate == M_FILL);
    assign dWEN    = (mstate == M_WB);
    assign ccwrite = dREN && wen;        // Write miss or S upgrade
    assign daddr   = dWEN ? {tag_arr[p_idx], p_idx, 3'b000} : {addr[31:3], 3'b000};
    assign dstore  = ccsnoopdone ? snoop_data_q : data_arr[p_idx];

    // Snoop lookup
    assign s_idx   = ccsnoopaddr[5:3];
    assign s_tag   = ccsnoopaddr[31:6];
    assign s_state = state_arr[s_idx];
    assign s_hit   = (s_state != INVALID) && (tag_arr[s_idx] == s_tag);

    always_ff @(posedge CLK) begin
        if (rst) begin
            mstate      <= M_IDLE;
            ccsnoopdone <= 1'b0;
            ccsnoophit  <= 1'b0;
            ccdirty     <= 1'b0;
            for (int i = 0; i < `L1_SETS; i++) begin
                state_arr[i] <= INVALID;
            end
        end else begin
            ccsnoopdone <= ccsnoop;                               // Answer one cycle later
            ccsnoophit  <= ccsnoop && s_hit;
            ccdirty     <= ccsnoop && s_hit && (s_state == MODIFIED);
            case (mstate)
                M_IDLE: begin
                    if (wen && p_done) begin
                        state_arr[p_idx] <= MODIFIED;             // E or M write hit
                    end else if ((ren || wen) && !ccsnoop && !p_done) begin
                        mstate <= victim_dirty ? M_WB : M_FILL;
                    end
                end
                M_WB: begin
                    if (!dwait) begin
                        state_arr[p_idx] <= INVALID;              // Victim now safe in L2
                        mstate           <= M_FILL;
                    end
                end
                M_FILL: begin
                    if (!dwait) begin
                        state_arr[p_idx] <= ccwrite ? MODIFIED :
                                            (ccexclusive ? EXCLUSIVE : SHARED);
                        mstate           <= M_IDLE;               // Request retires as a hit
                    end
                end
                default: mstate <= M_IDLE;
            endcase
            // Snoop downgrade
            // The bus never snoops the set being installed
            if (ccsnoop && s_hit) begin
                state_arr[s_idx] <= ccinv ? INVALID : SHARED;
            end
        end
    end

    // Tags and data
    always_ff @(posedge CLK) begin
        if (ccsnoop) begin
            snoop_data_q <= data_arr[s_idx];                      // Old contents even mid refill
        end
        if (mstate == M_FILL && !dwait) begin
            tag_arr[p_idx]  <= p_tag;
            data_arr[p_idx] <= dload;
        end else if (wen && p_done) begin
            data_arr[p_idx][{p_woff, 5'd0} +: 32] <= wdata;
        end
    end

    a_req_excl: assert property (@(posedge CLK) disable iff (rst) !(dREN && dWEN))
        else $error("l1_dcache %0d: dREN and dWEN both high", CPU_ID);

endmodule

// ==== verilog/coh_pkg.sv ====
`include "coh_defs.svh"

package coh_pkg;

    typedef logic [31:0] word_t;    // One data word
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [63:0] block_t;   // Upper word is word offset 1

    // Address split: tag 31:6, index 5:3, word 2
    typedef logic [31-`L1_INDEX_BITS-3:0]    tag_t;
    typedef logic [`L1_INDEX_BITS-1:0]       index_t;
    typedef logic [$clog2(`NUM_CPUS)-1:0]    cpu_id_t;

    typedef enum logic [1:0] {INVALID, SHARED, EXCLUSIVE, MODIFIED} mesi_t;

    // Bus controller phases
    typedef enum logic [3:0] {
        IDLE, GRANT_R, GRANT_RX, SNOOP, TRANSFER,
        READ_L2, WRITE_L2, BUS_TO_CACHE, WRITEBACK
    } bus_state_t;

    typedef enum logic [1:0] {L2_FREE, L2_BUSY, L2_ACCESS} l2_state_t;

endpackage

// ==== verilog/coh_defs.svh ====
`ifndef COH_DEFS_SVH
`define COH_DEFS_SVH

// Number of L1 data caches on the bus
`define NUM_CPUS 2

// L1 geometry, direct mapped with two-word blocks
`define L1_SETS       8
`define L1_INDEX_BITS 3

// Backing store size in 32-bit words
`define L2_WORDS 256

// Cycles in L2_BUSY before each L2_ACCESS
`define L2_LATENCY 2

`endif
